// ==== src.f ====
common/rv32i_pkg.sv
mem/load_extend.sv
mem/dmem_request.sv
mem/mem_stage.sv
hdl/writeback_reg.sv
hdl/mem_pipe_top.sv
tb/tb_clock_gen.sv
tb/dmem_model.sv
tb/tb_mem_pipe.sv

// ==== Bender.yml ====
package:
  name: rv32i_mem_stage

sources:
  - common/rv32i_pkg.sv
  - mem/load_extend.sv
  - mem/dmem_request.sv
  - mem/mem_stage.sv
  - hdl/writeback_reg.sv
  - hdl/mem_pipe_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/dmem_model.sv
      - tb/tb_mem_pipe.sv

// ==== tb/tb_mem_pipe.sv ====
`timescale 1ns/1ps

module tb_mem_pipe
    import rv32i_pkg::*;
();

    localparam int n_instr    = 70;
    localparam int rst_cycles = 8;

    logic     clk;
    logic     rst;
    logic     ex_valid;
    logic     ex_mem_read;
    logic     ex_mem_write;
    logic     ex_regf_we;
    funct3_t  ex_funct3;
    word_t    ex_alu_result;
    word_t    ex_rs2_v;
    reg_idx_t ex_rd_s;
    word_t    dmem_rdata;
    logic     dmem_resp;
    word_t    dmem_addr;
    mask_t    dmem_rmask;
    mask_t    dmem_wmask;
    word_t    dmem_wdata;
    logic     stall;
    logic     wb_valid;
    logic     wb_regf_we;
    reg_idx_t wb_rd_s;
    word_t    wb_rd_v;

    word_t shadow [16];
    string cur_test = "reset";
    int    errors = 0;
    int    errs_at_start = 0;
    int    tests_ok = 0;
    int    tests_bad = 0;
    logic  outstanding;   // request sent, response not yet seen

    tb_clock_gen u_clock (.clk(clk), .rst(rst));
    dmem_model u_mem (.*);
    mem_pipe_top dut (.*);

    always @(posedge clk)
    begin
        if (rst || dmem_resp)
            outstanding <= 1'b0;
        else if (|dmem_rmask || |dmem_wmask)
            outstanding <= 1'b1;
    end

    a_stall: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && (ex_mem_read || ex_mem_write)) |-> (stall == !dmem_resp))
    else
    begin
        errors++;
        $display("stall does not track the pending access in test %s", cur_test);
    end

    a_no_stall: assert property (@(posedge clk) disable iff (rst)
        !(ex_valid && (ex_mem_read || ex_mem_write)) |-> !stall)
    else
    begin
        errors++;
        $display("stall raised without a memory access in test %s", cur_test);
    end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> ($stable(wb_rd_v) && $stable(wb_valid) && $stable(wb_rd_s)
                   && $stable(wb_regf_we)))
    else
    begin
        errors++;
        $display("writeback outputs changed during a stall in test %s", cur_test);
    end

    a_single: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> (dmem_rmask == '0 && dmem_wmask == '0))
    else
    begin
        errors++;
        $display("request issued a second time before its response in test %s", cur_test);
    end

    a_idle: assert property (@(posedge clk) !ex_valid |-> (dmem_rmask == '0 && dmem_wmask == '0))
    else
    begin
        errors++;
        $display("request present while ex_valid is low in test %s", cur_test);
    end

    a_reset: assert property (@(posedge clk) rst |=> (!wb_valid && !wb_regf_we))
    else
    begin
        errors++;
        $display("writeback valid or write enable set after reset");
    end

    task automatic check_eq(input string what, input word_t exp, input word_t act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        errs_at_start = errors;
    endtask

    task automatic end_test();
        int n;
        n = errors - errs_at_start;
        if (n == 0)
            tests_ok++;
        else
            tests_bad++;
        $display("test %s: %s, %0d errors", cur_test, (n == 0) ? "ok" : "failed", n);
    endtask

    // byte, halfword or word enables moved to the addressed lane
    function automatic mask_t width_mask(input funct3_t f3, input logic [1:0] off);
        case (f3[1:0])
            2'b00:   return mask_t'(4'b0001 << off);
            2'b01:   return mask_t'(4'b0011 << off);
            default: return 4'b1111;
        endcase
    endfunction

    function automatic word_t place_store(input funct3_t f3, input word_t data, input int off);
        word_t w;
        mask_t m;
        w = '0;
        m = width_mask(f3, 2'(off));
        for (int b = 0; b < 4; b++)
            if (m[b])
                w[8*b +: 8] = data[8*(b - off) +: 8];
        return w;
    endfunction

    function automatic word_t load_exp(input funct3_t f3, input word_t w, input int off);
        logic [15:0] lane;
        lane = 16'(w >> (8 * off));
        case (f3)
            f3_lb:   return {{24{lane[7]}}, lane[7:0]};
            f3_lbu:  return {24'h0, lane[7:0]};
            f3_lh:   return {{16{lane[15]}}, lane};
            f3_lhu:  return {16'h0, lane};
            default: return w;
        endcase
    endfunction

    task automatic mem_access(input logic is_store, input funct3_t f3, input word_t addr,
                              input word_t data);
        reg_idx_t rd;
        word_t    exp_wdata;
        mask_t    m;
        int       idx;
        int       off;
        rd  = 5'($urandom);
        idx = int'(addr[5:2]);
        off = int'(addr[1:0]);
        m   = width_mask(f3, addr[1:0]);
        ex_valid      = 1'b1;
        ex_mem_read   = !is_store;
        ex_mem_write  = is_store;
        ex_funct3     = f3;
        ex_alu_result = addr;
        ex_rs2_v      = data;
        ex_rd_s       = rd;
        ex_regf_we    = !is_store;
        #1;
        check_eq("dmem_addr", {addr[31:2], 2'b00}, dmem_addr);
        if (is_store)
        begin
            exp_wdata = place_store(f3, data, off);
            check_eq("dmem_wmask", word_t'(m), word_t'(dmem_wmask));
            check_eq("dmem_wdata", exp_wdata, dmem_wdata);
            for (int b = 0; b < 4; b++)
                if (m[b])
                    shadow[idx][8*b +: 8] = exp_wdata[8*b +: 8];
        end
        else
            check_eq("dmem_rmask", word_t'(m), word_t'(dmem_rmask));
        do @(negedge clk); while (!dmem_resp);
        @(negedge clk);
        ex_valid = 1'b0;
        if (!is_store)
            check_eq("wb_rd_v", load_exp(f3, shadow[idx], off), wb_rd_v);
        check_eq("wb_rd_s", word_t'(rd), word_t'(wb_rd_s));
        check_eq("wb_valid", 1, word_t'(wb_valid));
        check_eq("wb_regf_we", word_t'(!is_store), word_t'(wb_regf_we));
    endtask

    task automatic alu_op(input word_t value);
        reg_idx_t rd;
        rd = 5'($urandom);
        ex_valid      = 1'b1;
        ex_mem_read   = 1'b0;
        ex_mem_write  = 1'b0;
        ex_funct3     = 3'($urandom);
        ex_alu_result = value;
        ex_rs2_v      = $urandom;
        ex_rd_s       = rd;
        ex_regf_we    = 1'b1;
        #1;
        check_eq("dmem_rmask", 0, word_t'(dmem_rmask));
        check_eq("dmem_wmask", 0, word_t'(dmem_wmask));
        check_eq("stall", 0, word_t'(stall));
        @(negedge clk);
        ex_valid = 1'b0;
        check_eq("wb_rd_v", value, wb_rd_v);   // exactly one cycle later
        check_eq("wb_rd_s", word_t'(rd), word_t'(wb_rd_s));
        check_eq("wb_valid", 1, word_t'(wb_valid));
        check_eq("wb_regf_we", 1, word_t'(wb_regf_we));
    endtask

    // bubble that still carries a load or store and a write enable
    task automatic drive_bubble();
        ex_valid      = 1'b0;
        ex_mem_read   = 1'($urandom);
        ex_mem_write  = !ex_mem_read;
        ex_funct3     = f3_lw;
        ex_alu_result = $urandom;
        ex_regf_we    = 1'b1;
        @(negedge clk);
        check_eq("wb_valid", 0, word_t'(wb_valid));
        check_eq("wb_regf_we", 0, word_t'(wb_regf_we));
    endtask

    initial
    begin
        void'($urandom(32'hc482));
        ex_valid      = 1'b0;
        ex_mem_read   = 1'b0;
        ex_mem_write  = 1'b0;
        ex_regf_we    = 1'b0;
        ex_funct3     = '0;
        ex_alu_result = '0;
        ex_rs2_v      = '0;
        ex_rd_s       = '0;
        wait (!rst);
        @(negedge clk);
        for (int i = 0; i < 16; i++)
            shadow[i] = u_mem.mem[i];

        start_test("reset");
        check_eq("wb_valid", 0, word_t'(wb_valid));
        check_eq("wb_regf_we", 0, word_t'(wb_regf_we));
        check_eq("dmem_rmask", 0, word_t'(dmem_rmask));
        check_eq("dmem_wmask", 0, word_t'(dmem_wmask));
        end_test();

        start_test("loads");
        for (int n = 0; n < 2; n++)
        begin
            int w;
            w = $urandom_range(0, 15);
            for (int off = 0; off < 4; off++)
            begin
                mem_access(1'b0, f3_lb, word_t'(w * 4 + off), '0);
                mem_access(1'b0, f3_lbu, word_t'(w * 4 + off), '0);
            end
            for (int off = 0; off < 4; off += 2)
            begin
                mem_access(1'b0, f3_lh, word_t'(w * 4 + off), '0);
                mem_access(1'b0, f3_lhu, word_t'(w * 4 + off), '0);
            end
            mem_access(1'b0, f3_lw, word_t'(w * 4), '0);
        end
        end_test();

        // each store is read back as a full word to see the merge
        start_test("stores");
        for (int n = 0; n < 2; n++)
        begin
            int w;
            w = $urandom_range(0, 15);
            for (int off = 0; off < 4; off++)
            begin
                mem_access(1'b1, f3_sb, word_t'(w * 4 + off), $urandom);
                mem_access(1'b0, f3_lw, word_t'(w * 4), '0);
            end
            for (int off = 0; off < 4; off += 2)
            begin
                mem_access(1'b1, f3_sh, word_t'(w * 4 + off), $urandom);
                mem_access(1'b0, f3_lw, word_t'(w * 4), '0);
            end
            mem_access(1'b1, f3_sw, word_t'(w * 4), $urandom);
            mem_access(1'b0, f3_lw, word_t'(w * 4), '0);
        end
        end_test();

        start_test("pass_through");
        for (int n = 0; n < 8; n++)
            alu_op($urandom);
        end_test();

        start_test("bubbles");
        for (int n = 0; n < 4; n++)
        begin
            alu_op($urandom);
            drive_bubble();
        end
        end_test();

        $display("%0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // worst case is well under 10 cycles per instruction
    initial
    begin
        repeat (n_instr * 10 + rst_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the memory never answered", n_instr * 10 + rst_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tb/dmem_model.sv ====
`timescale 1ns/1ps

module dmem_model
    import rv32i_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t dmem_addr,
    input  mask_t dmem_rmask,
    input  mask_t dmem_wmask,
    input  word_t dmem_wdata,
    output word_t dmem_rdata,
    output logic  dmem_resp
);

    localparam int depth = 16;

    word_t       mem [depth];
    logic        pending;
    int unsigned wait_left;   // extra cycles before the response pulse
    logic [3:0]  idx;
    mask_t       wmask_q;
    word_t       wdata_q;

    always @(posedge clk)
    begin
        dmem_resp <= 1'b0;
        if (rst)
        begin
            pending    <= 1'b0;
            dmem_rdata <= '0;
            // pattern depends on the whole word index
            for (int i = 0; i < depth; i++)
                mem[i] <= (i + 1) * 32'h9e37_79b9;
        end
        else if (pending)
        begin
            if (wait_left == 0)
            begin
                pending    <= 1'b0;
                dmem_resp  <= 1'b1;
                dmem_rdata <= mem[idx];
                for (int b = 0; b < 4; b++)
                    if (wmask_q[b])
                        mem[idx][8*b +: 8] <= wdata_q[8*b +: 8];   // only enabled lanes
            end
            else
                wait_left <= wait_left - 1;
        end
        else if (|dmem_rmask || |dmem_wmask)
        begin
            pending   <= 1'b1;
            wait_left <= $urandom_range(0, 3);
            idx       <= dmem_addr[5:2];
            wmask_q   <= dmem_wmask;
            wdata_q   <= dmem_wdata;
        end
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period = 4;   // 8 ns clock
    localparam int rst_cycles  = 8;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, like the rest of the stimulus
    initial
    begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== hdl/mem_pipe_top.sv ====
`timescale 1ns/1ps

module mem_pipe_top
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ex_valid,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  funct3_t  ex_funct3,
    input  word_t    ex_alu_result,
    input  word_t    ex_rs2_v,
    input  reg_idx_t ex_rd_s,
    input  logic     ex_regf_we,
    input  word_t    dmem_rdata,
    input  logic     dmem_resp,
    output word_t    dmem_addr,
    output mask_t    dmem_rmask,
    output mask_t    dmem_wmask,
    output word_t    dmem_wdata,
    output logic     stall,
    output logic     wb_valid,
    output reg_idx_t wb_rd_s,
    output word_t    wb_rd_v,
    output logic     wb_regf_we
);

    word_t load_value;

    mem_stage u_mem_stage (
        .clk        (clk),
        .rst        (rst),
        .valid      (ex_valid),
        .mem_read   (ex_mem_read),
        .mem_write  (ex_mem_write),
        .funct3     (ex_funct3),
        .alu_result (ex_alu_result),
        .rs2_v      (ex_rs2_v),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .stall      (stall),
        .load_value (load_value)
    );

    writeback_reg u_writeback_reg (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .valid      (ex_valid),
        .mem_read   (ex_mem_read),
        .regf_we    (ex_regf_we),
        .rd_s       (ex_rd_s),
        .alu_result (ex_alu_result),
        .load_value (load_value),
        .wb_valid   (wb_valid),
        .wb_regf_we (wb_regf_we),
        .wb_rd_s    (wb_rd_s),
        .wb_rd_v    (wb_rd_v)
    );

endmodule

// ==== hdl/writeback_reg.sv ====
`timescale 1ns/1ps

module writeback_reg
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     valid,
    input  logic     mem_read,
    input  logic     regf_we,
    input  reg_idx_t rd_s,
    input  word_t    alu_result,
    input  word_t    load_value,
    output logic     wb_valid,
    output logic     wb_regf_we,
    output reg_idx_t wb_rd_s,
    output word_t    wb_rd_v
);

    word_t rd_v;

    assign rd_v = mem_read ? load_value : alu_result;

    // control bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_valid   <= 1'b0;
            wb_regf_we <= 1'b0;
        end
        else if (!stall)
        begin
            wb_valid   <= valid;
            wb_regf_we <= valid & regf_we;   // bubbles never write the regfile
        end
    end

    // payload, only meaningful behind wb_valid
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            wb_rd_s <= rd_s;
            wb_rd_v <= rd_v;
        end
    end

endmodule

// ==== mem/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
    import rv32i_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    valid,
    input  logic    mem_read,
    input  logic    mem_write,
    input  funct3_t funct3,
    input  word_t   alu_result,
    input  word_t   rs2_v,
    input  word_t   dmem_rdata,
    input  logic    dmem_resp,
    output word_t   dmem_addr,
    output mask_t   dmem_rmask,
    output mask_t   dmem_wmask,
    output word_t   dmem_wdata,
    output logic    stall,
    output word_t   load_value
);

    logic [1:0] byte_off;

    assign byte_off = alu_result[1:0];

    // hold the pipe until memory answers, release in the resp cycle itself
    assign stall = valid & (mem_read | mem_write) & ~dmem_resp;

    dmem_request u_dmem_request (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .funct3     (funct3),
        .alu_result (alu_result),
        .rs2_v      (rs2_v),
        .dmem_resp  (dmem_resp),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask)
    );

    load_extend u_load_extend (
        .funct3     (funct3),
        .byte_off   (byte_off),
        .rdata      (dmem_rdata),
        .load_value (load_value)
    );

endmodule

// ==== mem/dmem_request.sv ====
`timescale 1ns/1ps

module dmem_request
    import rv32i_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    valid,
    input  logic    mem_read,
    input  logic    mem_write,
    input  funct3_t funct3,
    input  word_t   alu_result,
    input  word_t   rs2_v,
    input  logic    dmem_resp,
    output word_t   dmem_addr,
    output word_t   dmem_wdata,
    output mask_t   dmem_rmask,
    output mask_t   dmem_wmask
);

    logic                  access;
    logic                  issued;     // request already sent, waiting on resp
    logic [byte_off_w-1:0] off;
    logic [byte_off_w+2:0] shamt;
    mask_t                 rmask_raw;
    mask_t                 wmask_raw;
    word_t                 wdata_raw;

    assign access = valid & (mem_read | mem_write);
    assign off    = alu_result[byte_off_w-1:0];
    assign shamt  = {off, 3'b000};

    // inputs are held during the stall, so the request must go out only once
    always_ff @(posedge clk)
    begin
        if (rst)
            issued <= 1'b0;
        else if (dmem_resp)
            issued <= 1'b0;
        else if (access)
            issued <= 1'b1;
    end

    always_comb
    begin
        case (funct3)
            f3_lb, f3_lbu: rmask_raw = 4'b0001 << off;
            f3_lh, f3_lhu: rmask_raw = 4'b0011 << off;
            f3_lw:         rmask_raw = 4'b1111;
            default:       rmask_raw = '0;
        endcase
    end

    // store lane placement, other lanes left at zero
    always_comb
    begin
        case (funct3)
            f3_sb:
            begin
                wmask_raw = 4'b0001 << off;
                wdata_raw = word_t'(rs2_v[7:0]) << shamt;
            end
            f3_sh:
            begin
                wmask_raw = 4'b0011 << off;
                wdata_raw = word_t'(rs2_v[15:0]) << shamt;
            end
            f3_sw:
            begin
                wmask_raw = 4'b1111;
                wdata_raw = rs2_v;
            end
            default:
            begin
                wmask_raw = '0;
                wdata_raw = '0;
            end
        endcase
    end

    always_comb
    begin
        dmem_addr  = '0;
        dmem_rmask = '0;
        dmem_wmask = '0;
        dmem_wdata = '0;
        if (access && !issued)
        begin
            dmem_addr = {alu_result[31:byte_off_w], {byte_off_w{1'b0}}};   // word aligned
            if (mem_read)
                dmem_rmask = rmask_raw;
            if (mem_write)
            begin
                dmem_wmask = wmask_raw;
                dmem_wdata = wdata_raw;
            end
        end
    end

endmodule

// ==== mem/load_extend.sv ====
`timescale 1ns/1ps

module load_extend
    import rv32i_pkg::*;
(
    input  funct3_t     funct3,
    input  logic [1:0]  byte_off,
    input  word_t       rdata,
    output word_t       load_value
);

    logic [byte_off_w+2:0] shamt;
    word_t                 shifted;

    // bring the addressed lane down to bit 0
    assign shamt   = {byte_off, 3'b000};
    assign shifted = rdata >> shamt;

    // halfwords are assumed aligned, so offset is 0 or 2 here
    always_comb
    begin
        case (funct3)
            f3_lb:   load_value = {{24{shifted[7]}}, shifted[7:0]};
            f3_lbu:  load_value = {24'b0, shifted[7:0]};
            f3_lh:   load_value = {{16{shifted[15]}}, shifted[15:0]};
            f3_lhu:  load_value = {16'b0, shifted[15:0]};
            f3_lw:   load_value = rdata;
            default: load_value = '0;   // not a load code
        endcase
    end

endmodule

// ==== common/rv32i_pkg.sv ====
package rv32i_pkg;

    // datapath widths fixed by the ISA
    typedef logic [31:0] word_t;
    typedef logic [3:0]  mask_t;    // one enable bit per byte lane
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  reg_idx_t;

    // load width codes
    localparam funct3_t f3_lb  = 3'b000;
    localparam funct3_t f3_lh  = 3'b001;
    localparam funct3_t f3_lw  = 3'b010;
    localparam funct3_t f3_lbu = 3'b100;
    localparam funct3_t f3_lhu = 3'b101;

    // store width codes
    localparam funct3_t f3_sb  = 3'b000;
    localparam funct3_t f3_sh  = 3'b001;
    localparam funct3_t f3_sw  = 3'b010;

    // address bits that pick a byte within a word
    localparam int byte_off_w = 2;

endpackage
